/* src/axi_sram_consts.svh */
`ifndef AXI_SRAM_CONSTS_SVH
`define AXI_SRAM_CONSTS_SVH

// ------------------------------
// Memory geometry
// ------------------------------

// 32-bit words in the bank
`define AXI_SRAM_DEPTH_WORDS 256
// Index bits needed to address those words
`define AXI_SRAM_INDEX_BITS 8

// ------------------------------
// AXI response codes
// ------------------------------

`define AXI_RESP_OKAY 2'b00
`define AXI_RESP_SLVERR 2'b10
`define AXI_RESP_DECERR 2'b11

`endif

/* src/axi_sram_pkg.sv */
`include "axi_sram_consts.svh"

package axi_sram_pkg;

    // Plain vector types for the AXI fields
    typedef logic [31:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0] axi_strb_t;
    typedef logic [3:0] axi_id_t;
    typedef logic [7:0] axi_len_t;
    typedef logic [2:0] axi_size_t;
    typedef logic [1:0] axi_burst_t;
    typedef logic [1:0] axi_resp_t;

    // Word index into the bank
    typedef logic [`AXI_SRAM_INDEX_BITS-1:0] word_index_t;

    // ------------------------------
    // Channel payloads
    // ------------------------------

    typedef struct packed {
        axi_addr_t addr;
        axi_id_t id;
        axi_len_t len;
        axi_size_t size;
        axi_burst_t burst;
    } aw_req_t;

    // Read address has the same shape as write address
    typedef aw_req_t ar_req_t;

    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
        logic last;
    } w_beat_t;

    typedef struct packed {
        axi_id_t id;
        axi_resp_t resp;
    } b_resp_t;

    typedef struct packed {
        axi_id_t id;
        axi_data_t data;
        axi_resp_t resp;
        logic last;
    } r_beat_t;

    // Slave controller states
    typedef enum logic [1:0] {
        IDLE,
        READ_WAIT,
        READ_RESP,
        WRITE_RESP
    } ctrl_state_t;

endpackage

/* src/axi_write_lanes.sv */
`timescale 1ns/1ps

module axi_write_lanes (
    input  axi_sram_pkg::axi_addr_t addr,
    input  axi_sram_pkg::axi_size_t size,
    input  axi_sram_pkg::w_beat_t beat,
    output axi_sram_pkg::axi_strb_t lane_enable,
    output axi_sram_pkg::axi_data_t lane_data
);

    import axi_sram_pkg::*;

    axi_strb_t size_mask;

    // ------------------------------
    // Lane mask from size and offset
    // ------------------------------

    always_comb begin
        case (size)
            3'd0: size_mask = axi_strb_t'(4'b0001 << addr[1:0]);
            3'd1: size_mask = addr[1] ? 4'b1100 : 4'b0011;
            3'd2: size_mask = 4'b1111;
            // Wider than the bus, nothing gets written
            default: size_mask = 4'b0000;
        endcase
    end

    assign lane_enable = size_mask & beat.strb;

    // Narrow data already sits on its own lanes
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            if (lane_enable[i]) begin
                lane_data[i*8 +: 8] = beat.data[i*8 +: 8];
            end else begin
                lane_data[i*8 +: 8] = 8'h00;
            end
        end
    end

    // The controller only presents strobes on an accepted write,
    // so any live lane here belongs to a real halfword access
    halfword_aligned: assert final (
        !(size == 3'd1 && lane_enable != 4'b0000) || !addr[0]
    ) else $error("Halfword write to odd address %h", addr);

endmodule

/* src/sram_bank.sv */
`timescale 1ns/1ps
`include "axi_sram_consts.svh"

module sram_bank (
    input  logic clock,
    input  logic reset,
    input  logic wr_en,
    input  axi_sram_pkg::word_index_t wr_index,
    input  axi_sram_pkg::axi_strb_t wr_lanes,
    input  axi_sram_pkg::axi_data_t wr_data,
    input  logic rd_en,
    input  axi_sram_pkg::word_index_t rd_index,
    output axi_sram_pkg::axi_data_t rd_data
);

    import axi_sram_pkg::*;

    // Word storage, contents undefined until written
    axi_data_t mem [`AXI_SRAM_DEPTH_WORDS];

    // ------------------------------
    // Byte-lane write port
    // ------------------------------

    always_ff @(posedge clock) begin
        if (wr_en) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_lanes[i]) begin
                    mem[wr_index][i*8 +: 8] <= wr_data[i*8 +: 8];
                end
            end
        end
    end

    // ------------------------------
    // Registered read port
    // ------------------------------

    // Output holds its value until the next read
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_index];
        end
    end

    // Single port, the controller must never ask for both at once
    one_port_access: assert property (
        @(posedge clock) disable iff (reset)
        !(wr_en && rd_en)
    ) else $error("Bank read and write requested in the same cycle");

endmodule

/* src/axi_sram_ctrl.sv */
`timescale 1ns/1ps
`include "axi_sram_consts.svh"

module axi_sram_ctrl (
    input  logic clock,
    input  logic reset,

    // AXI slave channels
    input  axi_sram_pkg::aw_req_t aw,
    input  logic aw_valid,
    output logic aw_ready,
    input  axi_sram_pkg::w_beat_t w,
    input  logic w_valid,
    output logic w_ready,
    output axi_sram_pkg::b_resp_t b,
    output logic b_valid,
    input  logic b_ready,
    input  axi_sram_pkg::ar_req_t ar,
    input  logic ar_valid,
    output logic ar_ready,
    output axi_sram_pkg::r_beat_t r,
    output logic r_valid,
    input  logic r_ready,

    // Write lane logic
    output axi_sram_pkg::axi_addr_t lane_addr,
    output axi_sram_pkg::axi_size_t lane_size,
    output axi_sram_pkg::w_beat_t lane_beat,
    input  axi_sram_pkg::axi_strb_t lane_enable,
    input  axi_sram_pkg::axi_data_t lane_data,

    // Bank ports
    output logic wr_en,
    output axi_sram_pkg::word_index_t wr_index,
    output axi_sram_pkg::axi_strb_t wr_lanes,
    output axi_sram_pkg::axi_data_t wr_data,
    output logic rd_en,
    output axi_sram_pkg::word_index_t rd_index,
    input  axi_sram_pkg::axi_data_t rd_data
);

    import axi_sram_pkg::*;

    ctrl_state_t state;
    logic read_fire;
    logic write_fire;
    axi_resp_t ar_check;
    axi_resp_t aw_check;
    axi_id_t id_q;
    axi_resp_t resp_q;
    axi_data_t r_data_q;

    // Decode first, then burst and size
    function automatic axi_resp_t check_request(
        input axi_addr_t addr,
        input axi_len_t len,
        input axi_size_t size
    );
        axi_resp_t resp;
        if (addr >= axi_addr_t'(`AXI_SRAM_DEPTH_WORDS * 4)) begin
            resp = `AXI_RESP_DECERR;
        end else if (len != 8'd0 || size > 3'd2) begin
            resp = `AXI_RESP_SLVERR;
        end else begin
            resp = `AXI_RESP_OKAY;
        end
        return resp;
    endfunction

    // ------------------------------
    // Request acceptance
    // ------------------------------

    // Reads win, a write needs both AW and W present
    assign ar_ready = (state == IDLE);
    assign aw_ready = (state == IDLE) && aw_valid && w_valid && !ar_valid;
    assign w_ready = aw_ready;

    assign read_fire = ar_valid && ar_ready;
    assign write_fire = aw_ready;

    assign ar_check = check_request(ar.addr, ar.len, ar.size);
    assign aw_check = check_request(aw.addr, aw.len, aw.size);

    // ------------------------------
    // Bank access
    // ------------------------------

    assign wr_en = write_fire && (aw_check == `AXI_RESP_OKAY);
    assign rd_en = read_fire && (ar_check == `AXI_RESP_OKAY);
    assign wr_index = aw.addr[`AXI_SRAM_INDEX_BITS+1:2];
    assign rd_index = ar.addr[`AXI_SRAM_INDEX_BITS+1:2];
    assign wr_lanes = lane_enable;
    assign wr_data = lane_data;

    assign lane_addr = aw.addr;
    assign lane_size = aw.size;

    // Strobes only reach the lane logic on a write that lands
    always_comb begin
        lane_beat = w;
        if (!wr_en) begin
            lane_beat.strb = 4'b0000;
        end
    end

    // ------------------------------
    // State machine
    // ------------------------------

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (read_fire) begin
                        state <= READ_WAIT;
                    end else if (write_fire) begin
                        state <= WRITE_RESP;
                    end
                end
                READ_WAIT: state <= READ_RESP;
                READ_RESP: if (r_ready) state <= IDLE;
                WRITE_RESP: if (b_ready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // One transaction at a time, so B and R share the ID and code
    always_ff @(posedge clock) begin
        if (read_fire) begin
            id_q <= ar.id;
            resp_q <= ar_check;
        end else if (write_fire) begin
            id_q <= aw.id;
            resp_q <= aw_check;
        end
        if (state == READ_WAIT) begin
            r_data_q <= (resp_q == `AXI_RESP_OKAY) ? rd_data : '0;
        end
    end

    assign b_valid = (state == WRITE_RESP);
    assign r_valid = (state == READ_RESP);
    assign b = '{id: id_q, resp: resp_q};
    assign r = '{id: id_q, data: r_data_q, resp: resp_q, last: 1'b1};

    // ------------------------------
    // Response channel checks
    // ------------------------------

    r_hold: assert property (
        @(posedge clock) disable iff (reset)
        r_valid && !r_ready |=> r_valid && $stable(r)
    ) else $error("R payload changed under back-pressure");

    b_hold: assert property (
        @(posedge clock) disable iff (reset)
        b_valid && !b_ready |=> b_valid && $stable(b)
    ) else $error("B payload changed under back-pressure");

endmodule

/* src/axi_sram_top.sv */
`timescale 1ns/1ps

module axi_sram_top (
    input  logic clock,
    input  logic reset,
    input  axi_sram_pkg::aw_req_t aw,
    input  logic aw_valid,
    output logic aw_ready,
    input  axi_sram_pkg::w_beat_t w,
    input  logic w_valid,
    output logic w_ready,
    output axi_sram_pkg::b_resp_t b,
    output logic b_valid,
    input  logic b_ready,
    input  axi_sram_pkg::ar_req_t ar,
    input  logic ar_valid,
    output logic ar_ready,
    output axi_sram_pkg::r_beat_t r,
    output logic r_valid,
    input  logic r_ready
);

    import axi_sram_pkg::*;

    // Controller to lane logic
    axi_addr_t lane_addr;
    axi_size_t lane_size;
    w_beat_t lane_beat;
    axi_strb_t lane_enable;
    axi_data_t lane_data;

    // Controller to bank
    logic wr_en;
    word_index_t wr_index;
    axi_strb_t wr_lanes;
    axi_data_t wr_data;
    logic rd_en;
    word_index_t rd_index;
    axi_data_t rd_data;

    axi_sram_ctrl axi_sram_ctrl_inst (.*);

    axi_write_lanes axi_write_lanes_inst (
        .addr(lane_addr),
        .size(lane_size),
        .beat(lane_beat),
        .lane_enable(lane_enable),
        .lane_data(lane_data)
    );

    sram_bank sram_bank_inst (
        .clock(clock),
        .reset(reset),
        .wr_en(wr_en),
        .wr_index(wr_index),
        .wr_lanes(wr_lanes),
        .wr_data(wr_data),
        .rd_en(rd_en),
        .rd_index(rd_index),
        .rd_data(rd_data)
    );

endmodule

/* test/axi_sram_tb.sv */
`timescale 1ns/1ps
`include "axi_sram_consts.svh"

module axi_sram_tb;

    import axi_sram_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int N_FULL = 16;
    localparam int N_NARROW = 16;
    localparam int N_PRIO = 4;
    localparam int N_BP = 8;
    localparam int N_ERR = 7;
    localparam int TXN_COUNT = 2 * N_FULL + 2 * N_NARROW + 3 * N_PRIO + 3 * N_BP + N_ERR;
    localparam int BYTES = `AXI_SRAM_DEPTH_WORDS * 4;

    logic clock = 1'b0;
    logic reset;
    aw_req_t aw;
    logic aw_valid;
    logic aw_ready;
    w_beat_t w;
    logic w_valid;
    logic w_ready;
    b_resp_t b;
    logic b_valid;
    logic b_ready;
    ar_req_t ar;
    logic ar_valid;
    logic ar_ready;
    r_beat_t r;
    logic r_valid;
    logic r_ready;

    // Byte model with a written flag per byte
    logic [7:0] model_mem [BYTES];
    bit model_written [BYTES];
    word_index_t written_words [$];
    b_resp_t exp_b [$];
    r_beat_t exp_r [$];
    bit bp_mode = 1'b0;

    // Monitor state
    int edge_count = 0;
    int ar_edge = 0;
    int aw_edge = 0;
    bit b_hold = 1'b0;
    bit r_hold = 1'b0;
    bit b_seen = 1'b0;
    bit r_seen = 1'b0;
    b_resp_t held_b;
    r_beat_t held_r;

    axi_sram_top axi_sram_top_inst (.*);

    always #50 clock = ~clock;

    // ------------------------------
    // Failure reporting
    // ------------------------------

    task automatic abort_run(input string why);
        $display("** FAIL **");
        $fatal(1, why);
    endtask

    task automatic check_b(input b_resp_t exp, input b_resp_t act, input string what);
        if (act !== exp) begin
            $display("** Error at %t: %s expected id %h resp %h, got id %h resp %h",
                $time, what, exp.id, exp.resp, act.id, act.resp);
            abort_run("B channel mismatch");
        end
    endtask

    task automatic check_r(input r_beat_t exp, input r_beat_t act, input string what);
        if (act !== exp) begin
            $write("** Error at %t: %s expected id %h data %h resp %h last %b",
                $time, what, exp.id, exp.data, exp.resp, exp.last);
            $display(", got id %h data %h resp %h last %b",
                act.id, act.data, act.resp, act.last);
            abort_run("R channel mismatch");
        end
    endtask

    task automatic check_flag(input logic exp, input logic act, input string what);
        if (act !== exp) begin
            $display("** Error at %t: %s expected %b, got %b", $time, what, exp, act);
            abort_run("Handshake signal mismatch");
        end
    endtask

    task automatic check_count(input int exp, input int act, input string what);
        if (act != exp) begin
            $display("** Error at %t: %s expected edge %0d, got edge %0d", $time, what, exp, act);
            abort_run("Response timing mismatch");
        end
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------

    // Decode range first, then burst length and beat size
    function automatic axi_resp_t predict_resp(input aw_req_t req);
        if (req.addr > axi_addr_t'(BYTES - 1)) return `AXI_RESP_DECERR;
        if (req.len != 0) return `AXI_RESP_SLVERR;
        if (req.size > 2) return `AXI_RESP_SLVERR;
        return `AXI_RESP_OKAY;
    endfunction

    function automatic axi_strb_t lane_mask(input aw_req_t req, input axi_strb_t strb);
        axi_strb_t mask;
        case (req.size)
            3'd0: mask = axi_strb_t'(1 << req.addr[1:0]);
            3'd1: mask = req.addr[1] ? 4'b1100 : 4'b0011;
            default: mask = 4'b1111;
        endcase
        return mask & strb;
    endfunction

    function automatic r_beat_t predict_r(input ar_req_t req);
        r_beat_t beat;
        int base;
        beat.id = req.id;
        beat.resp = predict_resp(req);
        beat.last = 1'b1;
        beat.data = '0;
        base = {req.addr[31:2], 2'b00};
        if (beat.resp == `AXI_RESP_OKAY) begin
            for (int i = 0; i < 4; i++) beat.data[i*8 +: 8] = model_mem[base + i];
        end
        return beat;
    endfunction

    task automatic apply_write(input aw_req_t req, input w_beat_t beat);
        axi_strb_t lanes;
        int base;
        lanes = lane_mask(req, beat.strb);
        base = {req.addr[31:2], 2'b00};
        if (predict_resp(req) == `AXI_RESP_OKAY) begin
            for (int i = 0; i < 4; i++) begin
                if (lanes[i]) begin
                    model_mem[base + i] = beat.data[i*8 +: 8];
                    model_written[base + i] = 1'b1;
                end
            end
        end
    endtask

    function automatic aw_req_t make_req(input axi_addr_t addr, input axi_len_t len,
                                         input axi_size_t size);
        aw_req_t req;
        req.addr = addr;
        req.id = axi_id_t'($urandom);
        req.len = len;
        req.size = size;
        req.burst = 2'b01;
        return req;
    endfunction

    // ------------------------------
    // Stimulus
    // ------------------------------

    // Called 5 ns after an edge, returns at the same phase once all responses are back
    task automatic issue(input bit do_wr, input bit do_rd, input aw_req_t awq,
                         input w_beat_t wq, input ar_req_t arq);
        bit read_ok;
        aw = awq;
        w = wq;
        ar = arq;
        aw_valid = do_wr;
        w_valid = do_wr;
        ar_valid = do_rd;
        while (aw_valid || ar_valid) begin
            @(posedge clock);
            // Read is predicted before any write it beat
            if (ar_valid && ar_ready) begin
                read_ok = 1'b1;
                for (int i = 0; i < 4; i++) begin
                    if (predict_resp(arq) == `AXI_RESP_OKAY
                        && !model_written[{arq.addr[31:2], 2'b00} + i]) read_ok = 1'b0;
                end
                if (!read_ok) begin
                    $display("Read issued to bytes that were never written, address %h", arq.addr);
                    abort_run("Invalid stimulus");
                end
                exp_r.push_back(predict_r(arq));
                #5 ar_valid = 1'b0;
            end else if (aw_valid && aw_ready) begin
                check_flag(1'b1, w_ready, "w_ready on the write handshake");
                exp_b.push_back('{id: awq.id, resp: predict_resp(awq)});
                apply_write(awq, wq);
                #5;
                aw_valid = 1'b0;
                w_valid = 1'b0;
            end else begin
                #5;
            end
        end
        while (exp_b.size() + exp_r.size() != 0) begin
            @(posedge clock);
            #5;
        end
    endtask

    task automatic write_word(input aw_req_t req, input axi_data_t data, input axi_strb_t strb);
        issue(1'b1, 1'b0, req, '{data: data, strb: strb, last: 1'b1}, '0);
    endtask

    task automatic read_word(input ar_req_t req);
        issue(1'b0, 1'b1, '0, '0, req);
    endtask

    function automatic axi_addr_t pick_written();
        word_index_t idx;
        idx = written_words[$urandom % written_words.size()];
        return axi_addr_t'({idx, 2'b00});
    endfunction

    // Random back-pressure stretches on B and R
    always @(posedge clock) begin
        #5;
        b_ready = bp_mode ? ($urandom % 3 == 0) : 1'b1;
        r_ready = bp_mode ? ($urandom % 3 == 0) : 1'b1;
    end

    // ------------------------------
    // Response monitor
    // ------------------------------

    always @(posedge clock) begin
        if (!reset) begin
            edge_count++;
            if (b_hold) begin
                check_flag(1'b1, b_valid, "b_valid under back-pressure");
                check_b(held_b, b, "B payload under back-pressure");
            end
            if (r_hold) begin
                check_flag(1'b1, r_valid, "r_valid under back-pressure");
                check_r(held_r, r, "R payload under back-pressure");
            end
            if (b_valid || r_valid) begin
                check_flag(1'b0, ar_ready, "ar_ready while a response is pending");
                check_flag(1'b0, aw_ready, "aw_ready while a response is pending");
                check_flag(1'b0, w_ready, "w_ready while a response is pending");
            end
            check_flag(1'b0, ar_valid && (aw_ready || w_ready),
                "write accepted over a waiting read");
            if (ar_valid && ar_ready) ar_edge = edge_count;
            if (aw_valid && aw_ready) aw_edge = edge_count;
            if (r_valid && !r_seen) check_count(ar_edge + 2, edge_count, "r_valid rise");
            if (b_valid && !b_seen) check_count(aw_edge + 1, edge_count, "b_valid rise");
            if (b_valid && b_ready) begin
                if (exp_b.size() == 0) abort_run("B response with no write outstanding");
                check_b(exp_b.pop_front(), b, "B response");
            end
            if (r_valid && r_ready) begin
                if (exp_r.size() == 0) abort_run("R beat with no read outstanding");
                check_r(exp_r.pop_front(), r, "R beat");
            end
            b_hold = b_valid && !b_ready;
            r_hold = r_valid && !r_ready;
            held_b = b;
            held_r = r;
            b_seen = b_valid;
            r_seen = r_valid;
        end
    end

    // Watchdog sized from the transaction count
    initial begin
        repeat (TXN_COUNT * 40 + RESET_CYCLES) @(posedge clock);
        $display("Test did not finish within %0d cycles", TXN_COUNT * 40 + RESET_CYCLES);
        abort_run("Timeout");
    end

    initial begin
        axi_addr_t addr;
        axi_size_t size;
        $timeformat(-9, 1, " ns", 12);
        void'($urandom(32'h2f98));
        reset = 1'b1;
        aw = '0;
        w = '0;
        ar = '0;
        aw_valid = 1'b0;
        w_valid = 1'b0;
        ar_valid = 1'b0;
        b_ready = 1'b0;
        r_ready = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #5 reset = 1'b0;

        // Full words, each read back
        for (int i = 0; i < N_FULL; i++) begin
            written_words.push_back(word_index_t'($urandom));
            addr = axi_addr_t'({written_words[i], 2'b00});
            write_word(make_req(addr, 8'd0, 3'd2), $urandom, 4'hf);
            read_word(make_req(addr, 8'd0, 3'd2));
        end

        // Byte and halfword merges into written words
        for (int i = 0; i < N_NARROW; i++) begin
            size = axi_size_t'($urandom % 2);
            addr = pick_written();
            addr[1:0] = (size == 0) ? 2'($urandom) : {1'($urandom), 1'b0};
            write_word(make_req(addr, 8'd0, size), $urandom, axi_strb_t'($urandom));
            read_word(make_req({addr[31:2], 2'b00}, 8'd0, 3'd2));
        end

        // Read and write together, read sees the old word
        for (int i = 0; i < N_PRIO; i++) begin
            addr = pick_written();
            issue(1'b1, 1'b1, make_req(addr, 8'd0, 3'd2),
                '{data: $urandom, strb: 4'hf, last: 1'b1}, make_req(addr, 8'd0, 3'd2));
            read_word(make_req(addr, 8'd0, 3'd2));
        end

        // A write stays waiting while the held read response drains
        bp_mode = 1'b1;
        for (int i = 0; i < N_BP; i++) begin
            addr = pick_written();
            issue(1'b1, 1'b1, make_req(addr, 8'd0, 3'd2),
                '{data: $urandom, strb: 4'hf, last: 1'b1}, make_req(addr, 8'd0, 3'd2));
            read_word(make_req(addr, 8'd0, 3'd2));
        end
        bp_mode = 1'b0;

        // ------------------------------
        // Error responses
        // ------------------------------
        // Out-of-range write whose low bits alias a written word
        addr = pick_written();
        write_word(make_req(addr + 32'h400, 8'd0, 3'd2), $urandom, 4'hf);
        read_word(make_req(32'h0000_1000, 8'd0, 3'd2));
        write_word(make_req(addr, 8'd3, 3'd2), $urandom, 4'hf);
        read_word(make_req(addr, 8'd0, 3'd2));
        write_word(make_req(addr, 8'd0, 3'd3), $urandom, 4'hf);
        read_word(make_req(addr, 8'd0, 3'd2));
        read_word(make_req(addr, 8'd1, 3'd2));

        repeat (2) @(posedge clock);
        $display("** PASS **");
        $finish;
    end

endmodule

/* axi_sram_top.f */
+incdir+src
src/axi_sram_pkg.sv
src/axi_write_lanes.sv
src/sram_bank.sv
src/axi_sram_ctrl.sv
src/axi_sram_top.sv
test/axi_sram_tb.sv
